/* source/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// apb address and data widths
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

// slot field is the top nibble of the address
`define SOC_SLOT_LSB 12
`define SOC_SLOT_W (`SOC_ADDR_W - `SOC_SLOT_LSB)

// byte lanes below the word offset
`define SOC_BYTE_W 2

// word offset inside one slot
`define SOC_OFS_W (`SOC_SLOT_LSB - `SOC_BYTE_W)

// decoder covers slots 0 to 8
`define SOC_SLOT_NUM 9

// interrupt lines from the peripherals outside this subsystem
`define SOC_EXT_INT_W 4

// clock cycles per uart bit
`define SOC_UART_DIV 8

// start, eight data bits, stop
`define SOC_UART_FRAME_W 10

// led pins
`define SOC_LED_W 4

`endif

/* source/soc_bus_pkg.sv */
`include "soc_config.svh"

package soc_bus_pkg;

	// one address word, two ways to look at it
	typedef union packed {
		logic [`SOC_ADDR_W-1:0] word;
		struct packed {
			logic [`SOC_SLOT_W-1:0] slot;
			logic [`SOC_OFS_W-1:0]  ofs;
			logic [`SOC_BYTE_W-1:0] byte_sel;
		} fld;
	} apb_addr_u;

	// host side single register access
	typedef struct packed {
		logic                   write;
		apb_addr_u              addr;
		logic [`SOC_DATA_W-1:0] wdata;
	} host_req_t;

	// returned with rsp_valid
	typedef struct packed {
		logic [`SOC_DATA_W-1:0] rdata;
		logic                   err;
	} host_rsp_t;

	// master to slave phase signals
	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		apb_addr_u              paddr;
		logic [`SOC_DATA_W-1:0] pwdata;
	} apb_req_t;

	// slave to master
	typedef struct packed {
		logic                   pready;
		logic [`SOC_DATA_W-1:0] prdata;
	} apb_rsp_t;

endpackage

/* source/soc_periph_pkg.sv */
`include "soc_config.svh"

package soc_periph_pkg;

	// decoder slots in use, same places as the full soc
	typedef enum logic [`SOC_SLOT_W-1:0] {
		SLOT_INT  = 4'd0,
		SLOT_UART = 4'd1,
		SLOT_LED  = 4'd8
	} slot_e;

	// interrupt controller word offsets
	localparam logic [`SOC_OFS_W-1:0] INT_PEND_OFS = 10'd0;
	localparam logic [`SOC_OFS_W-1:0] INT_MASK_OFS = 10'd1;
	// write one to clear, reads zero
	localparam logic [`SOC_OFS_W-1:0] INT_CLR_OFS  = 10'd2;

	// uart word offsets
	localparam logic [`SOC_OFS_W-1:0] UART_DATA_OFS = 10'd0;
	// busy in bit 0
	localparam logic [`SOC_OFS_W-1:0] UART_STAT_OFS = 10'd1;

	// led word offset
	localparam logic [`SOC_OFS_W-1:0] LED_OFS = 10'd0;

	// interrupt sources
	// uart_done lands in bit 0, ext above it
	typedef struct packed {
		logic [`SOC_EXT_INT_W-1:0] ext;
		logic                      uart_done;
	} int_src_t;

endpackage

/* source/apb_master.sv */
`include "soc_config.svh"

module apb_master import soc_bus_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req_valid,
	input  host_req_t req,
	output apb_req_t  apb,
	input  apb_rsp_t  apb_rsp,
	output logic      rsp_valid,
	output host_rsp_t rsp,
	input  logic      err
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} state_e;

	state_e    state;
	// request held for both phases
	host_req_t req_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req_valid) begin
						state <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					state <= ST_ACCESS;
				end
				ST_ACCESS: begin
					// slave done, hand the result back
					if (apb_rsp.pready) begin
						state     <= ST_IDLE;
						rsp_valid <= 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// payload only, qualified by state and rsp_valid
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req_valid) begin
			req_q <= req;
		end
		if (state == ST_ACCESS && apb_rsp.pready) begin
			rsp.rdata <= apb_rsp.prdata;
			rsp.err   <= err;
		end
	end

	// phase outputs
	always_comb begin
		apb.psel    = (state != ST_IDLE);
		apb.penable = (state == ST_ACCESS);
		apb.pwrite  = req_q.write;
		apb.paddr   = req_q.addr;
		apb.pwdata  = req_q.wdata;
	end

	// host keeps to one request in flight
	a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> state == ST_IDLE)
		else $error("apb_master: request strobe while a transfer is in flight");

	// access only ever follows a setup cycle
	a_setup_first: assert property (@(posedge clk) disable iff (rst)
		$rose(apb.penable) |-> apb.psel && $past(apb.psel && !apb.penable))
		else $error("apb_master: penable raised without a setup phase");

endmodule

/* source/apb_decoder.sv */
`include "soc_config.svh"

module apb_decoder import soc_bus_pkg::*, soc_periph_pkg::*; (
	input  apb_req_t apb,
	output apb_rsp_t apb_rsp,
	output logic     err,
	output apb_req_t int_req,
	output apb_req_t uart_req,
	output apb_req_t led_req,
	input  apb_rsp_t int_rsp,
	input  apb_rsp_t uart_rsp,
	input  apb_rsp_t led_rsp
);

	// one bit per decoder slot
	logic [`SOC_SLOT_NUM-1:0] slot_hit;
	logic                     mapped;

	always_comb begin
		slot_hit = '0;
		// slots 9 and up never hit
		if (apb.psel && apb.paddr.fld.slot < `SOC_SLOT_NUM) begin
			slot_hit[apb.paddr.fld.slot] = 1'b1;
		end
	end

	assign mapped = slot_hit[SLOT_INT] | slot_hit[SLOT_UART] | slot_hit[SLOT_LED];

	// empty slot, answered here
	assign err = apb.psel & ~mapped;

	// shared bus, psel per slot
	always_comb begin
		int_req       = apb;
		int_req.psel  = slot_hit[SLOT_INT];
		uart_req      = apb;
		uart_req.psel = slot_hit[SLOT_UART];
		led_req       = apb;
		led_req.psel  = slot_hit[SLOT_LED];
	end

	// return path
	always_comb begin
		if (slot_hit[SLOT_INT]) begin
			apb_rsp = int_rsp;
		end else if (slot_hit[SLOT_UART]) begin
			apb_rsp = uart_rsp;
		end else if (slot_hit[SLOT_LED]) begin
			apb_rsp = led_rsp;
		end else begin
			// unmapped, zero data with no wait state
			apb_rsp.pready = apb.psel & apb.penable;
			apb_rsp.prdata = '0;
		end
	end

	// single target, and every access phase gets its ready
	always_comb begin
		a_one_target: assert #0 ($onehot0({int_req.psel, uart_req.psel, led_req.psel}) &&
			(!(apb.psel && apb.penable) || apb_rsp.pready))
			else $error("apb_decoder: bad select fan-out or missing ready");
	end

endmodule

/* source/int_controller.sv */
`include "soc_config.svh"

module int_controller import soc_bus_pkg::*, soc_periph_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  apb_req_t apb,
	output apb_rsp_t apb_rsp,
	input  int_src_t src,
	output logic     irq
);

	localparam int SRC_W = $bits(int_src_t);

	logic [SRC_W-1:0] pend;
	// one enables the source onto irq
	logic [SRC_W-1:0] mask;
	logic [SRC_W-1:0] clr;
	logic             wr_en;

	// write lands in the access phase
	assign wr_en = apb.psel & apb.penable & apb.pwrite;

	// clear strobe for this cycle
	always_comb begin
		clr = '0;
		if (wr_en && apb.paddr.fld.ofs == INT_CLR_OFS) begin
			clr = apb.pwdata[SRC_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= '0;
			mask <= '0;
		end else begin
			// sticky, a live source beats the clear
			pend <= (pend & ~clr) | src;
			if (wr_en && apb.paddr.fld.ofs == INT_MASK_OFS) begin
				mask <= apb.pwdata[SRC_W-1:0];
			end
		end
	end

	// any enabled pending source
	assign irq = |(pend & mask);

	// read back, unused offsets give zero
	always_comb begin
		apb_rsp.pready = apb.psel & apb.penable;
		apb_rsp.prdata = '0;
		case (apb.paddr.fld.ofs)
			INT_PEND_OFS: begin
				apb_rsp.prdata[SRC_W-1:0] = pend;
			end
			INT_MASK_OFS: begin
				apb_rsp.prdata[SRC_W-1:0] = mask;
			end
			default: begin
				apb_rsp.prdata = '0;
			end
		endcase
	end

endmodule

/* source/uart_tx.sv */
`include "soc_config.svh"

module uart_tx import soc_bus_pkg::*, soc_periph_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  apb_req_t apb,
	output apb_rsp_t apb_rsp,
	output logic     tx,
	output logic     done
);

	localparam int FRAME_W = `SOC_UART_FRAME_W;
	localparam int BAUD_W  = $clog2(`SOC_UART_DIV);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`SOC_UART_DIV - 1);

	logic               busy;
	logic [BAUD_W-1:0]  baud_cnt;
	// index of the bit on the line
	logic [3:0]         bit_cnt;
	// line bits, lsb goes out first
	logic [FRAME_W-1:0] shift;
	logic [7:0]         data_q;
	logic               start;
	logic               baud_tick;
	logic               last_bit;

	// data write only taken when idle
	assign start = apb.psel & apb.penable & apb.pwrite & ~busy &
		(apb.paddr.fld.ofs == UART_DATA_OFS);

	assign baud_tick = busy && (baud_cnt == BAUD_LAST);
	assign last_bit  = (bit_cnt == 4'(FRAME_W - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			// all ones keeps the line idle high
			shift    <= '1;
			data_q   <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy     <= 1'b1;
				baud_cnt <= '0;
				bit_cnt  <= '0;
				// stop, data, start
				shift    <= {1'b1, apb.pwdata[7:0], 1'b0};
				data_q   <= apb.pwdata[7:0];
			end else if (busy) begin
				baud_cnt <= baud_tick ? '0 : baud_cnt + 1'b1;
				if (baud_tick) begin
					shift   <= {1'b1, shift[FRAME_W-1:1]};
					bit_cnt <= bit_cnt + 1'b1;
					// end of stop bit
					if (last_bit) begin
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
			end
		end
	end

	assign tx = shift[0];

	// data and status readback
	always_comb begin
		apb_rsp.pready = apb.psel & apb.penable;
		apb_rsp.prdata = '0;
		case (apb.paddr.fld.ofs)
			UART_DATA_OFS: apb_rsp.prdata[7:0] = data_q;
			UART_STAT_OFS: apb_rsp.prdata[0]   = busy;
			default:       apb_rsp.prdata      = '0;
		endcase
	end

	// frame must leave the line at the stop level
	a_idle_high: assert property (@(posedge clk) disable iff (rst)
		!busy |-> tx)
		else $error("uart_tx: line low while idle");

endmodule

/* source/led_driver.sv */
`include "soc_config.svh"

module led_driver import soc_bus_pkg::*, soc_periph_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  apb_req_t              apb,
	output apb_rsp_t              apb_rsp,
	output logic [`SOC_LED_W-1:0] led
);

	logic led_hit;

	// only the one offset is decoded
	assign led_hit = (apb.paddr.fld.ofs == LED_OFS);

	always_ff @(posedge clk) begin
		if (rst) begin
			led <= '0;
		end else if (apb.psel && apb.penable && apb.pwrite && led_hit) begin
			// low data bits drive the pins
			led <= apb.pwdata[`SOC_LED_W-1:0];
		end
	end

	// upper bits read zero
	always_comb begin
		apb_rsp.pready = apb.psel & apb.penable;
		apb_rsp.prdata = '0;
		if (led_hit) begin
			apb_rsp.prdata[`SOC_LED_W-1:0] = led;
		end
	end

endmodule

/* source/apb_periph_top.sv */
`include "soc_config.svh"

module apb_periph_top import soc_bus_pkg::*, soc_periph_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      req_valid,
	input  host_req_t                 req,
	output logic                      rsp_valid,
	output host_rsp_t                 rsp,
	input  logic [`SOC_EXT_INT_W-1:0] ext_int,
	output logic                      irq,
	output logic                      tx,
	output logic [`SOC_LED_W-1:0]     led
);

	// master side
	apb_req_t apb;
	apb_rsp_t apb_rsp;
	logic     dec_err;

	// per slot
	apb_req_t int_req,  uart_req,  led_req;
	apb_rsp_t int_rsp,  uart_rsp,  led_rsp;

	logic     uart_done;
	int_src_t src;

	// uart in bit 0, outside lines above
	assign src.uart_done = uart_done;
	assign src.ext       = ext_int;

	apb_master u_master (
		.clk		(clk		),
		.rst		(rst		),
		.req_valid	(req_valid	),
		.req		(req		),
		.apb		(apb		),
		.apb_rsp	(apb_rsp	),
		.rsp_valid	(rsp_valid	),
		.rsp		(rsp		),
		.err		(dec_err	)
	);

	apb_decoder u_decoder (
		.apb		(apb		),
		.apb_rsp	(apb_rsp	),
		.err		(dec_err	),
		.int_req	(int_req	),
		.uart_req	(uart_req	),
		.led_req	(led_req	),
		.int_rsp	(int_rsp	),
		.uart_rsp	(uart_rsp	),
		.led_rsp	(led_rsp	)
	);

	// slot 0
	int_controller u_int (
		.clk		(clk		),
		.rst		(rst		),
		.apb		(int_req	),
		.apb_rsp	(int_rsp	),
		.src		(src		),
		.irq		(irq		)
	);

	// slot 1
	uart_tx u_uart (
		.clk		(clk		),
		.rst		(rst		),
		.apb		(uart_req	),
		.apb_rsp	(uart_rsp	),
		.tx			(tx			),
		.done		(uart_done	)
	);

	// slot 8
	led_driver u_led (
		.clk		(clk		),
		.rst		(rst		),
		.apb		(led_req	),
		.apb_rsp	(led_rsp	),
		.led		(led		)
	);

endmodule

/* testbench/tb_apb_periph.sv */
`include "soc_config.svh"

module tb_apb_periph import soc_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int UART_DIV   = `SOC_UART_DIV;
	// id, op, addr, wdata, ext, expected data, expected err
	localparam int VEC_COLS   = 7;
	localparam int VEC_MAX    = 64;
	// worst case per vector, a full frame plus slack
	localparam int VEC_CYCLES = 3 + 10 * UART_DIV + 20;

	localparam logic [3:0] OP_READ  = 4'h0;
	localparam logic [3:0] OP_WRITE = 4'h1;
	localparam logic [3:0] OP_UART  = 4'h2;
	localparam logic [3:0] OP_IRQ   = 4'h3;
	localparam logic [3:0] OP_END   = 4'hf;

	logic                      clk = 1'b0;
	logic                      rst;
	logic                      req_valid;
	host_req_t                 req;
	logic                      rsp_valid;
	host_rsp_t                 rsp;
	logic [`SOC_EXT_INT_W-1:0] ext_int;
	logic                      irq;
	logic                      tx;
	logic [`SOC_LED_W-1:0]     led;

	logic [31:0] vec_mem [0:VEC_COLS*VEC_MAX-1];
	int          n_vec = 0;
	int          errors = 0;
	int          failed_tests = 0;
	integer      seed = 32'h1b98a3d0;
	// bytes seen on the line, oldest first
	logic [7:0]  uart_q [$];

	apb_periph_top dut (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.ext_int   (ext_int),
		.irq       (irq),
		.tx        (tx),
		.led       (led)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_rsp(input host_rsp_t got, input host_rsp_t exp, input logic use_data);
		if (got.err !== exp.err || (use_data && got.rdata !== exp.rdata)) begin
			$display("Mismatch at %0t: response data %h err %b, expected data %h err %b",
				$time, got.rdata, got.err, exp.rdata, exp.err);
			errors++;
		end
	endtask

	task automatic check_led(input logic [`SOC_LED_W-1:0] got, input logic [`SOC_LED_W-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: led %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: irq %b, expected %b", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_uart_byte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: uart byte %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	// strobe for one cycle, then expect rsp_valid on the third falling edge
	task automatic run_request(input logic write, input logic [15:0] addr,
		input logic [31:0] wdata, output host_rsp_t got, output logic seen);
		req_valid     = 1'b1;
		req.write     = write;
		req.addr.word = addr;
		req.wdata     = wdata;
		seen          = 1'b0;
		got           = '0;
		for (int cyc = 1; cyc <= 3; cyc++) begin
			@(negedge clk);
			req_valid = 1'b0;
			if (rsp_valid === 1'b1) begin
				if (cyc < 3) begin
					$display("response came back after %0d cycles instead of 3 at %0t", cyc, $time);
					errors++;
				end else begin
					seen = 1'b1;
					got  = rsp;
				end
			end
		end
	endtask

	// tx sampled mid bit, start low, 8 data lsb first, stop high
	initial begin : uart_monitor
		logic [7:0] rx_byte;
		@(negedge rst);
		forever begin
			@(negedge tx);
			repeat (UART_DIV / 2) @(negedge clk);
			if (tx !== 1'b0) begin
				$display("uart start bit did not stay low at %0t", $time);
				errors++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (UART_DIV) @(negedge clk);
				rx_byte[i] = tx;
			end
			repeat (UART_DIV) @(negedge clk);
			if (tx !== 1'b1) begin
				$display("uart stop bit was low at %0t", $time);
				errors++;
			end
			// hand over once the stop bit is over
			repeat (UART_DIV / 2 + 1) @(negedge clk);
			uart_q.push_back(rx_byte);
		end
	end

	initial begin : watchdog
		longint limit_ns;
		wait (n_vec > 0);
		// reset cycles on top of the vector budget
		limit_ns = longint'(n_vec * VEC_CYCLES + 11) * CLK_PERIOD;
		#(limit_ns);
		$display("watchdog expired after %0d ns, the tests did not finish", limit_ns);
		$display("Finished with errors");
		$finish;
	end

	initial begin : main
		logic [7:0]  id;
		logic [3:0]  op;
		logic [15:0] addr;
		logic [31:0] wdata;
		logic [3:0]  ext;
		logic [31:0] exp_rdata;
		logic        exp_err;
		logic [31:0] pad;
		host_rsp_t   got;
		host_rsp_t   exp;
		logic        seen;
		logic [7:0]  rx_byte;
		int          waited;
		int          errors_before;

		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		ext_int   = '0;
		$readmemh("testbench/tb_golden_vectors.hex", vec_mem);
		while (n_vec < VEC_MAX && vec_mem[n_vec*VEC_COLS + 1][3:0] !== OP_END) begin
			n_vec++;
		end
		if (n_vec == 0) begin
			$display("no vectors were read from the golden file");
			errors++;
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		for (int v = 0; v < n_vec; v++) begin
			id            = vec_mem[v*VEC_COLS][7:0];
			op            = vec_mem[v*VEC_COLS + 1][3:0];
			addr          = vec_mem[v*VEC_COLS + 2][15:0];
			wdata         = vec_mem[v*VEC_COLS + 3];
			ext           = vec_mem[v*VEC_COLS + 4][3:0];
			exp_rdata     = vec_mem[v*VEC_COLS + 5];
			exp_err       = vec_mem[v*VEC_COLS + 6][0];
			errors_before = errors;
			ext_int       = ext;
			case (op)
				OP_READ, OP_WRITE: begin
					// uart data takes bits 7:0 only, junk above
					if (op == OP_WRITE && addr == 16'h1000) begin
						pad         = $random(seed);
						wdata[31:8] = pad[23:0];
					end
					run_request(op == OP_WRITE, addr, wdata, got, seen);
					if (!seen) begin
						$display("test %02h got no response 3 cycles after its strobe", id);
						errors++;
					end else begin
						exp.rdata = exp_rdata;
						exp.err   = exp_err;
						// error responses carry zero data for writes too
						check_rsp(got, exp, op == OP_READ || exp_err);
						// led follows in the response cycle
						if (op == OP_WRITE && addr == 16'h8000) begin
							check_led(led, wdata[3:0]);
						end
					end
				end
				OP_UART: begin
					waited = 0;
					while (uart_q.size() == 0 && waited < 12 * UART_DIV + 20) begin
						@(negedge clk);
						waited++;
					end
					if (uart_q.size() == 0) begin
						$display("test %02h saw no uart byte on tx", id);
						errors++;
					end else begin
						rx_byte = uart_q.pop_front();
						check_uart_byte(rx_byte, exp_rdata[7:0]);
					end
				end
				OP_IRQ: begin
					check_irq(irq, exp_rdata[0]);
				end
				default: begin
					$display("test %02h has an unknown operation %h", id, op);
					errors++;
				end
			endcase
			ext_int = '0;
			@(negedge clk);
			if (errors == errors_before) begin
				$display("test %02h op %0d addr %04h passed", id, op, addr);
			end else begin
				failed_tests++;
				$display("test %02h op %0d addr %04h failed", id, op, addr);
			end
		end

		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$display("%0d tests run, %0d tests failed, %0d check errors", n_vec, failed_tests, errors);
		$finish;
	end

endmodule

/* testbench/tb_golden_vectors.hex */
// id op addr wdata ext_int expected_rdata expected_err
// op 0 read, 1 write, 2 uart byte on tx, 3 irq level, f end of list
01 1 8000 00000005 0 00000000 0
02 0 8000 00000000 0 00000005 0
03 1 8000 0000000a 0 00000000 0
04 1 5000 0000000f 0 00000000 1
05 0 5000 00000000 0 00000000 1
06 0 c010 00000000 0 00000000 1
07 0 8000 00000000 0 0000000a 0
08 0 0000 00000000 0 00000000 0
09 1 1000 0000005a 0 00000000 0
0a 0 1004 00000000 0 00000001 0
0b 1 1000 000000c3 0 00000000 0
0c 0 1000 00000000 0 0000005a 0
0d 2 0000 00000000 0 0000005a 0
0e 0 1004 00000000 0 00000000 0
0f 0 0000 00000000 0 00000001 0
10 3 0000 00000000 0 00000000 0
11 1 0004 00000001 0 00000000 0
12 3 0000 00000000 0 00000001 0
13 0 0004 00000000 0 00000001 0
14 1 0008 00000001 0 00000000 0
15 0 0000 00000000 0 00000000 0
16 3 0000 00000000 0 00000000 0
17 0 0000 00000000 6 0000000c 0
18 0 0000 00000000 0 0000000c 0
19 3 0000 00000000 0 00000000 0
1a 1 0008 0000001f 0 00000000 0
1b 0 0000 00000000 0 00000000 0
1c 0 8000 00000000 0 0000000a 0
ff f 0000 00000000 0 00000000 0

/* sim.f */
+incdir+source
source/soc_bus_pkg.sv
source/soc_periph_pkg.sv
source/apb_master.sv
source/apb_decoder.sv
source/int_controller.sv
source/uart_tx.sv
source/led_driver.sv
source/apb_periph_top.sv
testbench/tb_apb_periph.sv

/* Makefile */
# Verilator build and run for the APB peripheral subsystem

VERILATOR ?= verilator
TOP       ?= tb_apb_periph
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Finished with no errors
SOURCES   := $(wildcard source/*.sv source/*.svh testbench/*.sv)
VECTORS   := testbench/tb_golden_vectors.hex

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the vector file path is relative to the project root
run: compile $(VECTORS)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
